//--- project.f
hw/icache_pkg.sv
hw/fetch_unit.sv
hw/icache_ctrl.sv
hw/icache_csr.sv
hw/icache_subsystem.sv
test/icache_checker.sv
test/tb_icache.sv

//--- run_sim.sh
#!/bin/sh
# builds the instruction cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_icache \
    -f project.f \
    -Mdir obj_dir -o sim_icache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_icache)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
    exit 0
else
    exit 1
fi

//--- test/icache_patterns.txt
// op: 01 fetch run, 02 register write, 03 register read, 04 redirect during a refill, 00 end
// then 4 hex digits of target or register, 8 hex digits of count, write data or expected value
// loop twice, misses then hits
01000000000008
01000000000008
03000100000008
03000200000008
// same index, alternating tags
01004000000001
01000000000001
01004000000001
01000000000001
0300020000000c
// clear counters and disable
02000100000000
02000200000000
02000000000000
01000000000004
01008000000002
03000000000000
03000200000006
03000100000000
// re-enable, earlier lines still cached
02000000000001
01000000000008
03000100000008
// invalidate with enable kept
02000000000003
01000000000004
03000000000001
0300020000000a
// redirect while the line at 0x0108 refills
01010000000002
04020000000003
03000200000010
01020000000003
0300010000000b
00000000000000

//--- test/tb_icache.sv
`timescale 1ns/10ps

module tb_icache
    import icache_pkg::*;
();

    localparam int    INDEX_W    = 4;
    localparam addr_t RESET_PC   = 16'h0000;
    localparam int    MAX_CMDS   = 64;
    localparam int    CLK_PERIOD = 100;

    logic      clk;
    logic      rst;
    logic      fetch_en;
    logic      redirect;
    addr_t     redirect_pc;
    logic      instr_valid;
    word_t     instr;
    addr_t     instr_pc;
    logic      fetch_busy;
    logic      mem_req_valid;
    addr_t     mem_req_addr;
    logic      mem_req_ready = 1'b0;
    word_t     mem_req_data = '0;
    logic      csr_wr;
    csr_addr_t csr_addr;
    word_t     csr_wdata;
    word_t     csr_rdata;

    logic [55:0] cmds [MAX_CMDS];
    logic [15:0] lfsr_state = 16'd4;
    logic        mem_pending = 1'b0;
    int          mem_wait = 0;
    int          checker_errors;
    int          tb_errors = 0;
    int          watchdog_cycles = 0;

    icache_subsystem #(
        .INDEX_W  (INDEX_W),
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clk           (clk),
        .rst           (rst),
        .fetch_en      (fetch_en),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .instr_pc      (instr_pc),
        .fetch_busy    (fetch_busy),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_ready (mem_req_ready),
        .mem_req_data  (mem_req_data),
        .csr_wr        (csr_wr),
        .csr_addr      (csr_addr),
        .csr_wdata     (csr_wdata),
        .csr_rdata     (csr_rdata)
    );

    icache_checker #(
        .INDEX_W  (INDEX_W),
        .RESET_PC (RESET_PC)
    ) i_checker (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .instr_pc      (instr_pc),
        .fetch_busy    (fetch_busy),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_ready (mem_req_ready),
        .csr_wr        (csr_wr),
        .csr_addr      (csr_addr),
        .csr_wdata     (csr_wdata),
        .csr_rdata     (csr_rdata),
        .error_count   (checker_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // memory model, 0 to 3 wait cycles per refill
    always @(negedge clk)
    begin
        if (rst || mem_req_ready)
        begin
            mem_req_ready = 1'b0;
            mem_pending   = 1'b0;
        end
        else if (mem_req_valid)
        begin
            if (!mem_pending)
            begin
                mem_pending = 1'b1;
                mem_wait    = 0;
                for (int b = 0; b < 2; b++)
                begin
                    lfsr_state = lfsr_next(lfsr_state);
                    mem_wait   = mem_wait * 2 + int'(lfsr_state[0]);
                end
            end
            if (mem_wait == 0)
            begin
                mem_req_ready = 1'b1;
                mem_req_data  = word_t'(mem_req_addr) ^ 32'hA5A5_0000;
            end
            else
                mem_wait--;
        end
    end

    task automatic fetch_run(input addr_t target, input int count, input logic in_refill);
        int seen;
        seen = 0;
        if (in_refill)
        begin
            fetch_en = 1'b1;
            @(negedge clk);
            while (!mem_req_valid)
                @(negedge clk);
        end
        redirect    = 1'b1;
        redirect_pc = target;
        @(negedge clk);
        redirect = 1'b0;
        fetch_en = 1'b1;
        while (seen < count)
        begin
            @(negedge clk);
            if (instr_valid)
                seen++;
        end
        // stop before the next request goes out
        fetch_en = 1'b0;
        while (fetch_busy)
            @(negedge clk);
    endtask

    task automatic write_reg(input csr_addr_t addr, input word_t data);
        csr_wr    = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        @(negedge clk);
        csr_wr    = 1'b0;
        csr_addr  = CSR_CTRL;
        csr_wdata = '0;
    endtask

    task automatic check_reg(input csr_addr_t addr, input word_t expected);
        csr_addr = addr;
        @(negedge clk);
        if (csr_rdata !== expected)
        begin
            $display("[FAIL] %0t: register %0d read 0x%h, expected 0x%h",
                $time, addr, csr_rdata, expected);
            tb_errors++;
        end
        csr_addr = CSR_CTRL;
    endtask

    initial
    begin
        int          n;
        int          total;
        logic [7:0]  op;
        addr_t       arg;
        word_t       val;
        rst         = 1'b1;
        fetch_en    = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        csr_wr      = 1'b0;
        csr_addr    = CSR_CTRL;
        csr_wdata   = '0;
        for (n = 0; n < MAX_CMDS; n++)
            cmds[n] = '0;
        $readmemh("test/icache_patterns.txt", cmds);
        total = 0;
        for (n = 0; n < MAX_CMDS; n++)
            if (cmds[n][55:48] == 8'h01 || cmds[n][55:48] == 8'h04)
                total += int'(cmds[n][31:0]);
        watchdog_cycles = 40 * total + 200;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        n = 0;
        while (n < MAX_CMDS && cmds[n][55:48] != 8'h00)
        begin
            op  = cmds[n][55:48];
            arg = cmds[n][47:32];
            val = cmds[n][31:0];
            case (op)
                8'h01: fetch_run(arg, int'(val), 1'b0);
                8'h02: write_reg(arg[1:0], val);
                8'h03: check_reg(arg[1:0], val);
                8'h04: fetch_run(arg, int'(val), 1'b1);
                default:
                begin
                    $display("unknown command %h in pattern entry %0d", op, n);
                    tb_errors++;
                end
            endcase
            n++;
        end
        repeat (4) @(negedge clk);
        $display("errors: checker %0d, testbench %0d", checker_errors, tb_errors);
        if (checker_errors == 0 && tb_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- test/icache_checker.sv
`timescale 1ns/10ps

module icache_checker
    import icache_pkg::*;
#(
    parameter int    INDEX_W  = 4,
    parameter addr_t RESET_PC = '0
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      instr_valid,
    input  word_t     instr,
    input  addr_t     instr_pc,
    input  logic      fetch_busy,
    input  logic      redirect,
    input  addr_t     redirect_pc,
    input  logic      mem_req_valid,
    input  addr_t     mem_req_addr,
    input  logic      mem_req_ready,
    input  logic      csr_wr,
    input  csr_addr_t csr_addr,
    input  word_t     csr_wdata,
    input  word_t     csr_rdata,
    output int        error_count
);

    localparam int ADDR_W = $bits(addr_t);
    localparam int LINES  = 1 << INDEX_W;
    localparam int TAG_W  = ADDR_W - INDEX_W - 2;

    logic             shadow_valid [LINES];
    logic [TAG_W-1:0] shadow_tag [LINES];
    logic             enable_model;
    count_t           exp_hits;
    count_t           exp_misses;
    addr_t            exp_pc;
    logic             refill_seen;
    addr_t            refill_addr;
    int               errors = 0;

    assign error_count = errors;

    task automatic report_fail(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        errors++;
    endtask

    function automatic count_t bump(input count_t value);
        return (value == '1) ? value : value + 16'd1;
    endfunction

    // would this address hit in the shadow array
    function automatic logic cached(input addr_t addr);
        logic [INDEX_W-1:0] idx;
        idx = addr[INDEX_W+1:2];
        return enable_model && shadow_valid[idx] && (shadow_tag[idx] == addr[ADDR_W-1:INDEX_W+2]);
    endfunction

    always @(posedge clk)
    begin
        logic [INDEX_W-1:0] idx;
        word_t              expected;
        if (rst)
        begin
            for (int i = 0; i < LINES; i++)
                shadow_valid[i] = 1'b0;
            enable_model = 1'b1;
            exp_hits     = '0;
            exp_misses   = '0;
            exp_pc       = RESET_PC;
            refill_seen  = 1'b0;
        end
        else
        begin
            // counters are only settled once the fetch path is quiet
            if (!csr_wr && !fetch_busy && !instr_valid)
            begin
                if (csr_addr == CSR_HITS && csr_rdata !== word_t'(exp_hits))
                    report_fail($sformatf("hit count 0x%h, model 0x%h", csr_rdata, exp_hits));
                if (csr_addr == CSR_MISSES && csr_rdata !== word_t'(exp_misses))
                    report_fail($sformatf("miss count 0x%h, model 0x%h", csr_rdata, exp_misses));
            end
            // a refill only serves an outstanding request
            if (mem_req_valid && !fetch_busy)
                report_fail("refill request while fetch_busy is low");
            if (instr_valid && fetch_busy)
                report_fail("fetch_busy high in the instr_valid cycle");
            if (csr_wr && csr_addr == CSR_CTRL)
            begin
                enable_model = csr_wdata[0];
                if (csr_wdata[1])
                    for (int i = 0; i < LINES; i++)
                        shadow_valid[i] = 1'b0;
            end
            if (csr_wr && csr_addr == CSR_HITS)
                exp_hits = '0;
            if (csr_wr && csr_addr == CSR_MISSES)
                exp_misses = '0;
            // every refill is one miss
            if (mem_req_valid && mem_req_ready)
            begin
                if (cached(mem_req_addr))
                    report_fail($sformatf("refill of cached address 0x%h", mem_req_addr));
                exp_misses = bump(exp_misses);
                if (enable_model)
                begin
                    idx               = mem_req_addr[INDEX_W+1:2];
                    shadow_valid[idx] = 1'b1;
                    shadow_tag[idx]   = mem_req_addr[ADDR_W-1:INDEX_W+2];
                end
                refill_seen = 1'b1;
                refill_addr = mem_req_addr;
            end
            if (instr_valid)
            begin
                expected = word_t'(instr_pc) ^ 32'hA5A5_0000;
                if (instr !== expected)
                    report_fail($sformatf("instr 0x%h at pc 0x%h, expected 0x%h",
                        instr, instr_pc, expected));
                if (instr_pc !== exp_pc)
                    report_fail($sformatf("instr_pc 0x%h, expected 0x%h", instr_pc, exp_pc));
                if (!(refill_seen && refill_addr == instr_pc))
                begin
                    if (!cached(instr_pc))
                        report_fail($sformatf("pc 0x%h served without refill", instr_pc));
                    exp_hits = bump(exp_hits);
                end
                exp_pc      = instr_pc + 16'd4;
                refill_seen = 1'b0;
            end
            if (redirect)
                exp_pc = redirect_pc;
        end
    end

endmodule

//--- hw/icache_subsystem.sv
`timescale 1ns/10ps

module icache_subsystem
    import icache_pkg::*;
#(
    parameter int    INDEX_W  = 4,
    parameter addr_t RESET_PC = '0
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      fetch_en,
    input  logic      redirect,
    input  addr_t     redirect_pc,
    output logic      instr_valid,
    output word_t     instr,
    output addr_t     instr_pc,
    output logic      fetch_busy,
    output logic      mem_req_valid,
    output addr_t     mem_req_addr,
    input  logic      mem_req_ready,
    input  word_t     mem_req_data,
    input  logic      csr_wr,
    input  csr_addr_t csr_addr,
    input  word_t     csr_wdata,
    output word_t     csr_rdata
);

    logic  cpu_req_valid;
    addr_t cpu_req_addr;
    logic  cpu_req_ready;
    word_t cpu_req_data;
    logic  cache_enable;
    logic  cache_invalidate;
    logic  hit_pulse;
    logic  miss_pulse;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) i_fetch (
        .clk           (clk),
        .rst           (rst),
        .fetch_en      (fetch_en),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_ready (cpu_req_ready),
        .cpu_req_data  (cpu_req_data),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .instr_pc      (instr_pc),
        .fetch_busy    (fetch_busy)
    );

    icache_ctrl #(
        .INDEX_W (INDEX_W)
    ) i_ctrl (
        .clk              (clk),
        .rst              (rst),
        .cache_enable     (cache_enable),
        .cache_invalidate (cache_invalidate),
        .cpu_req_valid    (cpu_req_valid),
        .cpu_req_addr     (cpu_req_addr),
        .cpu_req_ready    (cpu_req_ready),
        .cpu_req_data     (cpu_req_data),
        .mem_req_valid    (mem_req_valid),
        .mem_req_addr     (mem_req_addr),
        .mem_req_ready    (mem_req_ready),
        .mem_req_data     (mem_req_data),
        .hit_pulse        (hit_pulse),
        .miss_pulse       (miss_pulse)
    );

    icache_csr i_csr (
        .clk              (clk),
        .rst              (rst),
        .csr_wr           (csr_wr),
        .csr_addr         (csr_addr),
        .csr_wdata        (csr_wdata),
        .csr_rdata        (csr_rdata),
        .hit_pulse        (hit_pulse),
        .miss_pulse       (miss_pulse),
        .cache_enable     (cache_enable),
        .cache_invalidate (cache_invalidate)
    );

endmodule

//--- hw/icache_csr.sv
`timescale 1ns/10ps

module icache_csr
    import icache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      csr_wr,
    input  csr_addr_t csr_addr,
    input  word_t     csr_wdata,
    output word_t     csr_rdata,
    input  logic      hit_pulse,
    input  logic      miss_pulse,
    output logic      cache_enable,
    output logic      cache_invalidate
);

    logic   enable_q;
    logic   inval_q;
    count_t hits_q;
    count_t misses_q;

    // counters stick at all ones
    function automatic count_t sat_inc(input count_t value);
        return (value == '1) ? value : value + count_t'(1);
    endfunction

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            enable_q <= 1'b1;
            inval_q  <= 1'b0;
            hits_q   <= '0;
            misses_q <= '0;
        end
        else
        begin
            inval_q <= csr_wr && (csr_addr == CSR_CTRL) && csr_wdata[CTRL_INVAL_BIT];
            if (csr_wr && csr_addr == CSR_CTRL)
                enable_q <= csr_wdata[CTRL_ENABLE_BIT];
            if (csr_wr && csr_addr == CSR_HITS)
                hits_q <= '0;
            else if (hit_pulse)
                hits_q <= sat_inc(hits_q);
            if (csr_wr && csr_addr == CSR_MISSES)
                misses_q <= '0;
            else if (miss_pulse)
                misses_q <= sat_inc(misses_q);
        end
    end

    // invalidate bit always reads as zero
    always_comb
    begin
        case (csr_addr)
            CSR_CTRL:   csr_rdata = word_t'(enable_q);
            CSR_HITS:   csr_rdata = word_t'(hits_q);
            CSR_MISSES: csr_rdata = word_t'(misses_q);
            default:    csr_rdata = '0;
        endcase
    end

    assign cache_enable     = enable_q;
    assign cache_invalidate = inval_q;

    a_inval_pulse: assert property (@(posedge clk) disable iff (rst)
        cache_invalidate |=> !cache_invalidate);

endmodule

//--- hw/icache_ctrl.sv
`timescale 1ns/10ps

module icache_ctrl
    import icache_pkg::*;
#(
    parameter int INDEX_W = 4
)
(
    input  logic  clk,
    input  logic  rst,
    input  logic  cache_enable,
    input  logic  cache_invalidate,
    input  logic  cpu_req_valid,
    input  addr_t cpu_req_addr,
    output logic  cpu_req_ready,
    output word_t cpu_req_data,
    output logic  mem_req_valid,
    output addr_t mem_req_addr,
    input  logic  mem_req_ready,
    input  word_t mem_req_data,
    output logic  hit_pulse,
    output logic  miss_pulse
);

    localparam int ADDR_W = $bits(addr_t);
    localparam int LINES  = 1 << INDEX_W;
    localparam int TAG_W  = ADDR_W - INDEX_W - 2;

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    logic [LINES-1:0] valid_q;
    logic [TAG_W-1:0] tag_arr [LINES];
    word_t            data_arr [LINES];

    logic [INDEX_W-1:0] req_index;
    logic [TAG_W-1:0]   req_tag;
    logic               hit;
    logic               mem_done;
    logic               first_q;
    logic               inval_pending_q;
    addr_t              mem_addr_q;
    word_t              bypass_q;

    assign req_index = cpu_req_addr[INDEX_W+1:2];
    assign req_tag   = cpu_req_addr[ADDR_W-1:INDEX_W+2];
    assign hit       = cache_enable && valid_q[req_index] && (tag_arr[req_index] == req_tag);
    assign mem_done  = (state_q == REFILL) && mem_req_ready;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
            begin
                if (cpu_req_valid)
                    state_d = LOOKUP;
            end
            LOOKUP:
                state_d = hit ? IDLE : REFILL;
            REFILL:
            begin
                // uncached refill goes back through RESPOND
                if (mem_req_ready)
                    state_d = cache_enable ? LOOKUP : RESPOND;
            end
            RESPOND:
                state_d = IDLE;
            default:
                state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q         <= IDLE;
            first_q         <= 1'b0;
            inval_pending_q <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            // only the first lookup of a request is counted
            if (state_q == IDLE)
                first_q <= 1'b1;
            else if (state_q == LOOKUP)
                first_q <= 1'b0;
            if (cache_invalidate)
                inval_pending_q <= 1'b1;
            else if (state_q == IDLE)
                inval_pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            valid_q <= '0;
        else if (state_q == IDLE && inval_pending_q)
            valid_q <= '0;
        else if (mem_done && cache_enable)
            valid_q[req_index] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (mem_done)
        begin
            if (cache_enable)
            begin
                tag_arr[req_index]  <= req_tag;
                data_arr[req_index] <= mem_req_data;
            end
            bypass_q <= mem_req_data;
        end
        if (state_q == LOOKUP && !hit)
            mem_addr_q <= {cpu_req_addr[ADDR_W-1:2], 2'b00};
    end

    assign cpu_req_ready = (state_q == LOOKUP && hit) || (state_q == RESPOND);
    assign cpu_req_data  = (state_q == RESPOND) ? bypass_q : data_arr[req_index];
    assign mem_req_valid = (state_q == REFILL);
    assign mem_req_addr  = mem_addr_q;
    assign hit_pulse     = (state_q == LOOKUP) && first_q && hit;
    assign miss_pulse    = (state_q == LOOKUP) && first_q && !hit;

    a_mem_addr_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr));

    // each request is classified exactly once, in its first lookup
    a_pulse_exclusive: assert property (@(posedge clk) disable iff (rst)
        cpu_req_valid && state_q == IDLE |=> hit_pulse != miss_pulse);

    a_ready_state: assert property (@(posedge clk) disable iff (rst)
        cpu_req_ready |-> cpu_req_valid && (state_q == LOOKUP || state_q == RESPOND));

endmodule

//--- hw/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit
    import icache_pkg::*;
#(
    parameter addr_t RESET_PC = '0
)
(
    input  logic  clk,
    input  logic  rst,
    input  logic  fetch_en,
    input  logic  redirect,
    input  addr_t redirect_pc,
    output logic  cpu_req_valid,
    output addr_t cpu_req_addr,
    input  logic  cpu_req_ready,
    input  word_t cpu_req_data,
    output logic  instr_valid,
    output word_t instr,
    output addr_t instr_pc,
    output logic  fetch_busy
);

    addr_t pc_q;
    logic  req_q;
    logic  drop_q;
    addr_t redir_pc_q;
    logic  instr_valid_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc_q          <= RESET_PC;
            req_q         <= 1'b0;
            drop_q        <= 1'b0;
            instr_valid_q <= 1'b0;
        end
        else
        begin
            instr_valid_q <= 1'b0;
            if (!req_q)
            begin
                if (redirect)
                    pc_q <= redirect_pc;
                else if (fetch_en)
                    req_q <= 1'b1;
            end
            else if (cpu_req_ready)
            begin
                req_q  <= 1'b0;
                drop_q <= 1'b0;
                // a redirect seen during the request discards its response
                if (redirect)
                    pc_q <= redirect_pc;
                else if (drop_q)
                    pc_q <= redir_pc_q;
                else
                begin
                    pc_q          <= pc_q + addr_t'(4);
                    instr_valid_q <= 1'b1;
                end
            end
            else if (redirect)
                drop_q <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_q && redirect)
            redir_pc_q <= redirect_pc;
        if (req_q && cpu_req_ready)
        begin
            instr    <= cpu_req_data;
            instr_pc <= pc_q;
        end
    end

    assign cpu_req_valid = req_q;
    assign cpu_req_addr  = pc_q;
    assign instr_valid   = instr_valid_q;
    assign fetch_busy    = req_q || drop_q;

    a_req_addr_stable: assert property (@(posedge clk) disable iff (rst)
        cpu_req_valid && !cpu_req_ready |=> cpu_req_valid && $stable(cpu_req_addr));

endmodule

//--- hw/icache_pkg.sv
package icache_pkg;

    // byte address into the instruction space
    typedef logic [15:0] addr_t;

    // instruction or memory data word
    typedef logic [31:0] word_t;

    // saturating performance counter
    typedef logic [15:0] count_t;

    // register index on the control bus
    typedef logic [1:0] csr_addr_t;

    // register map
    localparam csr_addr_t CSR_CTRL   = 2'd0;
    localparam csr_addr_t CSR_HITS   = 2'd1;
    localparam csr_addr_t CSR_MISSES = 2'd2;

    // bit positions inside CSR_CTRL
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_INVAL_BIT  = 1;

    // cache controller states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        RESPOND
    } ctrl_state_t;

endpackage
